/* axis_packer_pkg.sv */
/*
	Shared beat type and lane helpers for the byte-stream packer.
	Every link between stages carries one beat_t together with a valid/ready pair.
	Stages pull these in with a wildcard import inside the module body.
*/
`default_nettype none

package axis_packer_pkg;

	// Number of byte lanes in one beat of the stream
	localparam int beat_bytes = 4;

	// One stream beat
	// Keep has one bit per lane and a set bit marks a real byte
	typedef struct packed {
		logic [beat_bytes*8-1:0] data;
		logic [beat_bytes-1:0]   keep;
		logic                    last;
	} beat_t;

	// Wide enough to hold every count from 0 up to beat_bytes
	typedef logic [$clog2(beat_bytes+1)-1:0] lane_count_t;

	// Number of real bytes marked in a keep mask
	function automatic lane_count_t count_lanes(input logic [beat_bytes-1:0] keep);
		lane_count_t total;
		total = '0;
		for (int i = 0; i < beat_bytes; i++)
		begin
			total = total + lane_count_t'(keep[i]);
		end
		return total;
	endfunction

	// Index of the lowest null lane, or beat_bytes when every lane holds a byte
	// Scanning from the top lets the lowest hit overwrite any higher one
	function automatic lane_count_t lowest_null_lane(input logic [beat_bytes-1:0] keep);
		lane_count_t index;
		index = lane_count_t'(beat_bytes);
		for (int i = beat_bytes - 1; i >= 0; i--)
		begin
			if (!keep[i])
			begin
				index = lane_count_t'(i);
			end
		end
		return index;
	endfunction

endpackage

`default_nettype wire

/* axis_packer_null_fold.sv */
/*
	Front stage of the packer.
	Beats with no real bytes are swallowed here so that later stages never see them.
	A last that arrives on such a beat is moved onto the beat held from the same packet.
	Packets made only of null beats vanish completely.
*/
`default_nettype none

module axis_packer_null_fold
(
	input  logic                   clk,
	input  logic                   sresetn,

	input  axis_packer_pkg::beat_t in_beat,
	input  logic                   in_valid,
	output logic                   in_ready,

	output axis_packer_pkg::beat_t out_beat,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import axis_packer_pkg::*;

	// The single beat we hold back until we know whether it ends the packet
	beat_t hold_beat;
	logic  hold_valid;

	logic  in_null;
	logic  hold_complete;
	logic  in_fire;
	logic  out_fire;
	logic  capture;
	logic  fold_last;

	assign in_null = (count_lanes(in_beat.keep) == '0);

	// A held beat that already carries last needs nothing more before it goes
	assign hold_complete = hold_valid && hold_beat.last;

	// Otherwise it is released as soon as the next real beat shows up behind it
	// That beat then takes its place in the same cycle
	assign out_beat  = hold_beat;
	assign out_valid = hold_complete || (hold_valid && in_valid && !in_null);
	assign out_fire  = out_valid && out_ready;

	// Null beats are always consumed
	// A real beat only has to wait when the held one cannot leave this cycle
	assign in_ready = in_null || !hold_valid || out_ready;
	assign in_fire  = in_valid && in_ready;

	assign capture = in_fire && !in_null;

	// Only fold onto a beat of the same packet, never onto one that already ended
	// A null last with an empty or finished hold is an empty packet and just drops
	assign fold_last = in_fire && in_null && in_beat.last && hold_valid && !hold_beat.last;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			hold_valid <= 1'b0;
		end
		else
		begin
			if (out_fire)
			begin
				hold_valid <= 1'b0;
			end
			// A capture in the same cycle as a release refills the register
			if (capture)
			begin
				hold_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			hold_beat <= in_beat;
		end
		else if (fold_last)
		begin
			hold_beat.last <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* axis_packer_align_stage.sv */
/*
	One registered alignment step of the packer.
	Bytes above the lowest null lane move down by one lane, closing that gap.
	The top level chains beat_bytes-1 of these, and stage_index says how many
	top lanes earlier stages have already settled.
*/
`default_nettype none

module axis_packer_align_stage
#(
	parameter int stage_index = 0
)
(
	input  logic                   clk,
	input  logic                   sresetn,

	input  axis_packer_pkg::beat_t in_beat,
	input  logic                   in_valid,
	output logic                   in_ready,

	output axis_packer_pkg::beat_t out_beat,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import axis_packer_pkg::*;

	// Highest lane this stage may touch
	// Lanes above it are either null or already in their final place
	localparam int top_lane = beat_bytes - stage_index - 1;

	lane_count_t             lowest;
	logic [beat_bytes*8-1:0] above_data;
	logic [beat_bytes-1:0]   above_keep;
	beat_t                   shifted;
	logic                    in_fire;

	assign lowest = lowest_null_lane(in_beat.keep);

	// Lane i of these views holds lane i+1 of the input
	assign above_data = in_beat.data >> 8;
	assign above_keep = in_beat.keep >> 1;

	always_comb
	begin
		shifted = in_beat;
		for (int i = 0; i <= top_lane; i++)
		begin
			if (lane_count_t'(i) >= lowest)
			begin
				if (i == top_lane)
				begin
					// Nothing eligible sits above the top lane, so it becomes a null
					shifted.data[i*8 +: 8] = 8'h00;
					shifted.keep[i]        = 1'b0;
				end
				else
				begin
					shifted.data[i*8 +: 8] = above_data[i*8 +: 8];
					shifted.keep[i]        = above_keep[i];
				end
			end
		end
	end

	// Take a new beat whenever the register is empty or is being drained now
	assign in_ready = !out_valid || out_ready;
	assign in_fire  = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			if (out_ready)
			begin
				out_valid <= 1'b0;
			end
			if (in_fire)
			begin
				out_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_fire)
		begin
			out_beat <= shifted;
		end
	end

endmodule

`default_nettype wire

/* axis_packer_combine_stage.sv */
/*
	Output stage of the packer.
	Beats arrive with their bytes packed from lane 0 and are appended above the
	bytes already held in the output register.
	The register is presented once every lane is filled or once it holds a last.
	An input that does not fit is split, and its remainder follows in the next word.
*/
`default_nettype none

module axis_packer_combine_stage
(
	input  logic                   clk,
	input  logic                   sresetn,

	input  axis_packer_pkg::beat_t in_beat,
	input  logic                   in_valid,
	output logic                   in_ready,

	output axis_packer_pkg::beat_t out_beat,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import axis_packer_pkg::*;

	// Output register
	logic [beat_bytes*8-1:0] reg_data;
	logic [beat_bytes-1:0]   reg_keep;
	logic                    reg_last;

	// Input lanes already moved out of a split beat
	lane_count_t base;

	lane_count_t             in_count;
	lane_count_t             fill_level;
	lane_count_t             free_lanes;
	lane_count_t             remaining;
	lane_count_t             take;
	logic                    out_fire;
	logic                    can_write;
	logic                    fits;
	logic                    write;
	logic [beat_bytes-1:0]   write_keep;
	logic [beat_bytes*8-1:0] aligned_data;
	logic [beat_bytes*8-1:0] merged_data;

	// Mask with the lowest n lanes set
	function automatic logic [beat_bytes-1:0] low_mask(input lane_count_t n);
		logic [beat_bytes-1:0] mask;
		for (int i = 0; i < beat_bytes; i++)
		begin
			mask[i] = (lane_count_t'(i) < n);
		end
		return mask;
	endfunction

	assign out_beat  = '{data: reg_data, keep: reg_keep, last: reg_last};
	assign out_valid = reg_last || (&reg_keep);
	assign out_fire  = out_valid && out_ready;

	// Nothing may land in a word that is waiting for a stalled consumer
	assign can_write = !out_valid || out_ready;

	// Held bytes are always contiguous from lane 0, so the count is also the
	// first free lane; a word leaving this cycle frees every lane
	assign fill_level = out_fire ? '0 : count_lanes(reg_keep);
	assign free_lanes = lane_count_t'(beat_bytes) - fill_level;

	// Bytes of the current input still to be placed
	assign in_count  = count_lanes(in_beat.keep);
	assign remaining = in_count - base;
	assign fits      = (remaining <= free_lanes);
	assign take      = fits ? remaining : free_lanes;

	// The input is only acknowledged once its last byte has been placed
	assign in_ready = can_write && fits;
	assign write    = in_valid && can_write;

	// Skip the lanes already used, then lift the rest above the held bytes
	assign aligned_data = (in_beat.data >> (8 * base)) << (8 * fill_level);
	assign write_keep   = low_mask(fill_level + take) & ~low_mask(fill_level);

	always_comb
	begin
		merged_data = reg_data;
		for (int i = 0; i < beat_bytes; i++)
		begin
			if (write_keep[i])
			begin
				merged_data[i*8 +: 8] = aligned_data[i*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			reg_keep <= '0;
			reg_last <= 1'b0;
			base     <= '0;
		end
		else
		begin
			if (out_fire)
			begin
				reg_keep <= '0;
				reg_last <= 1'b0;
			end
			if (write)
			begin
				reg_keep <= low_mask(fill_level + take);
				// On a split the last belongs to the remainder, not to this word
				reg_last <= fits && in_beat.last;
				base     <= fits ? '0 : base + take;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (write)
		begin
			reg_data <= merged_data;
		end
	end

endmodule

`default_nettype wire

/* axis_packer.sv */
/*
	Byte-stream packer for a beat_bytes-wide stream.
	Null bytes are removed and the remaining bytes are repacked into full words.
	Only the final word of a packet may be partial, packed from lane 0.
	The fold stage feeds beat_bytes-1 alignment stages, which feed the combine stage.
*/
`default_nettype none

module axis_packer
(
	input  logic                   clk,
	input  logic                   sresetn,

	input  axis_packer_pkg::beat_t in_beat,
	input  logic                   in_valid,
	output logic                   in_ready,

	output axis_packer_pkg::beat_t out_beat,
	output logic                   out_valid,
	input  logic                   out_ready
);
	import axis_packer_pkg::*;

	// Link k feeds alignment stage k, and the last link feeds the combine stage
	// Each link lives in its own block so the ready chain stays per signal
	for (genvar k = 0; k < beat_bytes; k++)
	begin : g_link
		beat_t beat;
		logic  valid;
		logic  ready;
	end

	axis_packer_null_fold fold
	(
		.clk       (clk),
		.sresetn   (sresetn),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (g_link[0].beat),
		.out_valid (g_link[0].valid),
		.out_ready (g_link[0].ready)
	);

	// Stage k may ignore its k top lanes, since earlier stages have settled them
	for (genvar k = 0; k < beat_bytes - 1; k++)
	begin : g_align
		axis_packer_align_stage
		#(
			.stage_index (k)
		)
		align
		(
			.clk       (clk),
			.sresetn   (sresetn),
			.in_beat   (g_link[k].beat),
			.in_valid  (g_link[k].valid),
			.in_ready  (g_link[k].ready),
			.out_beat  (g_link[k+1].beat),
			.out_valid (g_link[k+1].valid),
			.out_ready (g_link[k+1].ready)
		);
	end

	axis_packer_combine_stage combine
	(
		.clk       (clk),
		.sresetn   (sresetn),
		.in_beat   (g_link[beat_bytes-1].beat),
		.in_valid  (g_link[beat_bytes-1].valid),
		.in_ready  (g_link[beat_bytes-1].ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

/* tb_axis_packer.sv */
/*
	Self-checking testbench for the byte-stream packer.
	Input beats and expected output beats come from the tests data file, one test at a time.
	Each test may set the density of random input gaps and output back-pressure.
*/
`default_nettype none

module tb_axis_packer;
	import axis_packer_pkg::*;

	// One parsed line of the data file
	typedef struct packed {
		logic [7:0]      kind;
		beat_t           beat;
		logic [31:0]     value;
		logic [8*24-1:0] name;
	} record_t;

	logic        clk;
	logic        sresetn;
	beat_t       in_beat;
	logic        in_valid;
	logic        in_ready;
	beat_t       out_beat;
	logic        out_valid;
	logic        out_ready;

	record_t     records[$];
	beat_t       expected[$];
	// Expected beats released to the monitor so far, and the next one it compares
	int          expect_limit = 0;
	int          expect_next = 0;
	int          pressure_pct = 0;
	logic        idle_draw;
	logic [31:0] lfsr_state;

	axis_packer uut
	(
		.clk       (clk),
		.sresetn   (sresetn),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	// Right-shifting Galois LFSR with a maximal-length tap mask
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
	endfunction

	// True on about pct calls out of 100, built from seven fresh bits
	function automatic logic draw_chance(input int pct);
		int value;
		value = 0;
		for (int i = 0; i < 7; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = value * 2 + int'(lfsr_state[0]);
		end
		return (value * 100) < (pct * 128);
	endfunction

	// Byte-wide mask of the lanes marked in keep
	function automatic logic [beat_bytes*8-1:0] lane_bytes(input logic [beat_bytes-1:0] keep);
		logic [beat_bytes*8-1:0] mask;
		for (int i = 0; i < beat_bytes; i++)
		begin
			mask[i*8 +: 8] = {8{keep[i]}};
		end
		return mask;
	endfunction

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] wanted);
		if (actual !== wanted)
		begin
			stop_with_error($sformatf("Mismatch at time %0t: %s is 0x%h, expected 0x%h",
				$time, name, actual, wanted));
		end
	endtask

	// Reads every line up front, expected beats also go to their own queue
	task automatic load_tests();
		int                      fd;
		int                      ch;
		int                      got;
		int                      value;
		logic [8*24-1:0]         token;
		logic [8*24-1:0]         name;
		logic [beat_bytes-1:0]   keep;
		logic [beat_bytes*8-1:0] data;
		logic                    last;
		record_t                 rec;
		fd = $fopen("axis_packer_tests.txt", "r");
		if (fd == 0)
		begin
			stop_with_error("Could not open the test data file axis_packer_tests.txt");
		end
		else
		begin
			token = '0;
			while ($fscanf(fd, " %s", token) == 1)
			begin
				rec = '0;
				rec.kind = token[7:0];
				got = 1;
				case (token[7:0])
					"#":
					begin
						// Comment line, skip to its end
						ch = $fgetc(fd);
						while (ch != 10 && ch != -1)
						begin
							ch = $fgetc(fd);
						end
					end
					"T":
					begin
						name = '0;
						got = $fscanf(fd, " %s", name);
						rec.name = name;
					end
					"R":
					begin
						got = $fscanf(fd, " %d", value);
						rec.value = 32'(value);
					end
					"I", "O":
					begin
						got = ($fscanf(fd, " %b %h %b", keep, data, last) == 3) ? 1 : 0;
						rec.beat = '{data: data, keep: keep, last: last};
					end
					default: got = 0;
				endcase
				if (got != 1)
				begin
					stop_with_error($sformatf("Malformed line starting with %0s in the test data file",
						token));
				end
				if (rec.kind == "O")
				begin
					expected.push_back(rec.beat);
				end
				if (rec.kind != "#")
				begin
					records.push_back(rec);
				end
				token = '0;
			end
			$fclose(fd);
		end
	endtask

	// Called at a falling edge and returns at the falling edge before the transfer
	task automatic send_beat(input beat_t beat);
		int gaps;
		int waited;
		gaps = 0;
		while (idle_draw && gaps < 8)
		begin
			@(posedge clk);
			in_valid <= 1'b0;
			@(negedge clk);
			gaps++;
		end
		@(posedge clk);
		in_beat  <= beat;
		in_valid <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!in_ready)
		begin
			waited++;
			if (waited > 1000)
			begin
				stop_with_error($sformatf("Input beat with data 0x%h was never accepted",
					beat.data));
			end
			@(negedge clk);
		end
	endtask

	// Ends the input stream and waits until every released expected beat came out
	task automatic finish_test();
		int waited;
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (expect_next < expect_limit)
		begin
			waited++;
			if (waited > 1000)
			begin
				stop_with_error($sformatf("Expected output beat %0d never came out", expect_next));
			end
			@(negedge clk);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#5 clk = ~clk;
		end
	end

	// Draws back-pressure and the input gap decision once per cycle
	initial
	begin
		lfsr_state = 32'h7b01_62ca;
		out_ready <= 1'b0;
		idle_draw <= 1'b0;
		forever
		begin
			@(posedge clk);
			out_ready <= !draw_chance(pressure_pct);
			idle_draw <= draw_chance(pressure_pct);
		end
	end

	// Outputs are stable at the falling edge, and a beat seen here transfers on the next rise
	always @(negedge clk)
	begin
		if (sresetn && out_valid && out_ready)
		begin
			if (expect_next >= expect_limit)
			begin
				stop_with_error($sformatf("Unexpected output beat with data 0x%h", out_beat.data));
			end
			else
			begin
				check_value("out_beat.keep", 32'(out_beat.keep), 32'(expected[expect_next].keep));
				check_value("out_beat.data", out_beat.data & lane_bytes(expected[expect_next].keep),
					expected[expect_next].data & lane_bytes(expected[expect_next].keep));
				check_value("out_beat.last", 32'(out_beat.last), 32'(expected[expect_next].last));
				expect_next = expect_next + 1;
			end
		end
	end

	initial
	begin
		sresetn  <= 1'b0;
		in_beat  <= '0;
		in_valid <= 1'b0;
		load_tests();
		repeat (3) @(posedge clk);
		sresetn <= 1'b1;
		// The packer must stay silent until it sees input
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_value("out_valid", 32'(out_valid), 32'd0);
		end
		for (int r = 0; r < records.size(); r++)
		begin
			case (records[r].kind)
				"T":
				begin
					finish_test();
					$display("Running test %0s", records[r].name);
					for (int j = r + 1; j < records.size() && records[j].kind != "T"; j++)
					begin
						if (records[j].kind == "O")
						begin
							expect_limit++;
						end
					end
				end
				"R": pressure_pct = int'(records[r].value);
				"I": send_beat(records[r].beat);
				default: ;
			endcase
		end
		finish_test();
		// Stalled consumer, so a leftover beat stays visible on out_valid
		pressure_pct = 100;
		repeat (20) @(negedge clk);
		if (out_valid)
		begin
			stop_with_error("Output beats remain unconsumed at the end of the run");
		end
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* axis_packer_tests.txt */
# Columns: I or O, keep (binary, lane 3 first), data (hex, lane 3 first), last
# T name starts a test, R sets the percentage of idle input and stalled output cycles
T full_keep
I 1111 03020100 0
I 1111 07060504 1
O 1111 03020100 0
O 1111 07060504 1
T sparse_keep
I 1010 13ee11ee 0
I 0110 ee2221ee 0
I 0001 eeeeee30 0
I 1001 43eeee40 1
O 1111 22211311 0
O 0111 00434030 1
T null_last
R 30
I 1100 5150eeee 0
I 0101 ee61ee60 0
I 0000 eeeeeeee 1
I 0000 deadbeef 0
I 0000 deadbeef 1
O 1111 61605150 1
T split_input
R 60
I 0111 ee828180 0
I 1011 93ee9190 0
I 1110 a2a1a0ee 1
O 1111 90828180 0
O 1111 a1a09391 0
O 0001 000000a2 1

/* verilog.f */
axis_packer_pkg.sv
axis_packer_null_fold.sv
axis_packer_align_stage.sv
axis_packer_combine_stage.sv
axis_packer.sv
tb_axis_packer.sv

/* run_sim.sh */
#!/bin/sh
# Builds the packer testbench with Verilator and runs it.
# The script exits with the simulation's status, so a failed run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module tb_axis_packer -o tb_axis_packer
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/tb_axis_packer
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
	exit $sim_status
fi

exit 0
